/* compile.f */
source/icache_pkg.sv
source/icache_data_way.sv
source/icache_tag_array.sv
source/icache_ctrl.sv
source/icache_resp.sv
source/refill_memory.sv
source/icache_top.sv
tests/icache_properties.sv
tests/icache_tb.sv

/* Bender.yml */
package:
  name: icache

sources:
  - source/icache_pkg.sv
  - source/icache_data_way.sv
  - source/icache_tag_array.sv
  - source/icache_ctrl.sv
  - source/icache_resp.sv
  - source/refill_memory.sv
  - source/icache_top.sv
  - target: test
    files:
      - tests/icache_properties.sv
      - tests/icache_tb.sv

/* tests/icache_tb.sv */
`timescale 1ns/1ps

module icache_tb;

	localparam int MEM_LATENCY = 3;
	// about 230 fetches, each well under 20 cycles even on a miss, times a wide margin
	localparam int TIMEOUT_CYCLES = 20000;

	logic                    clk = 1'b0;
	logic                    rst;
	icache_pkg::fetch_addr_u addr;
	logic                    valid;
	logic                    flush;
	logic                    inv_valid;
	icache_pkg::fetch_addr_u inv_addr;
	logic [31:0]             inst;
	logic                    ready;
	logic                    hit;

	// fetches waiting for their response, oldest first
	logic [63:0] expect_q [$];
	logic [63:0] expected_addr;
	string       test_name = "reset";
	int          cycle_count = 0;
	logic [15:0] lfsr_state = 16'd50;
	logic [31:0] rand_bits;

	// last line refilled into each set
	logic [59:0] shadow_line [64];
	logic [63:0] shadow_valid = '0;

	icache_top #(
		.MEM_LATENCY (MEM_LATENCY)
	) u_dut (
		.clk       (clk),
		.rst       (rst),
		.addr      (addr),
		.valid     (valid),
		.flush     (flush),
		.inv_valid (inv_valid),
		.inv_addr  (inv_addr),
		.inst      (inst),
		.ready     (ready),
		.hit       (hit)
	);

	always #20 clk = ~clk;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string what, input logic [63:0] expected,
			input logic [63:0] actual);
		if (actual !== expected) begin
			fail_run($sformatf("** Error [%s] %s: expected %0h actual %0h",
				test_name, what, expected, actual));
		end
	endtask

	// backing store rule, memory wraps at 4 KiB
	function automatic logic [31:0] expected_inst(input logic [63:0] byte_addr);
		logic [31:0] word_addr;
		word_addr = {22'b0, byte_addr[11:2]};
		return (word_addr ^ 32'h5A5A_0000) + (word_addr * 32'd3);
	endfunction

	// galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 16'hB400;
		end
		return n;
	endfunction

	task automatic draw_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	function automatic logic line_is_cached(input logic [63:0] a);
		return shadow_valid[a[9:4]] && (shadow_line[a[9:4]] == a[63:4]);
	endfunction

	task automatic record_refill(input logic [63:0] a);
		shadow_line[a[9:4]]  = a[63:4];
		shadow_valid[a[9:4]] = 1'b1;
	endtask

	task automatic present(input logic [63:0] a);
		addr.raw = a;
		valid    = 1'b1;
		expect_q.push_back(a);
	endtask

	// one fetch, held until ready; hit checked where the shadow is sure
	task automatic fetch_word(input logic [63:0] a, input logic must_miss);
		logic seen_hit;
		logic sure_hit;
		int   waited;
		sure_hit = line_is_cached(a);
		@(negedge clk);
		present(a);
		#1;
		seen_hit = hit;
		if (sure_hit) begin
			check_value("hit", 1, seen_hit);
		end
		if (must_miss) begin
			check_value("hit", 0, seen_hit);
		end
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (ready !== 1'b1);
		valid = 1'b0;
		if (seen_hit) begin
			check_value("hit latency", 1, waited);
		end else begin
			record_refill(a);
		end
	endtask

	// alternate two cached lines, one request per cycle
	task automatic stream_hits(input logic [63:0] base_a, input logic [63:0] base_b);
		logic [63:0] a;
		@(negedge clk);
		for (int i = 0; i < 8; i++) begin
			a = (((i % 2) == 0) ? base_a : base_b) + 64'((i / 2) * 4);
			present(a);
			#1;
			check_value("hit", 1, hit);
			@(negedge clk);
			check_value("ready", 1, ready);
		end
		valid = 1'b0;
	endtask

	task automatic invalidate(input logic [63:0] a);
		@(negedge clk);
		inv_addr.raw = a;
		inv_valid    = 1'b1;
		@(negedge clk);
		inv_valid = 1'b0;
		if (line_is_cached(a)) begin
			shadow_valid[a[9:4]] = 1'b0;
		end
	endtask

	// flush sampled with the request, so no response follows
	task automatic flushed_fetch(input logic [63:0] a);
		@(negedge clk);
		addr.raw = a;
		valid    = 1'b1;
		flush    = 1'b1;
		#1;
		check_value("hit", 1, hit);
		@(negedge clk);
		check_value("ready", 0, ready);
		valid = 1'b0;
		flush = 1'b0;
		@(negedge clk);
		check_value("ready", 0, ready);
	endtask

	// response checker
	always @(negedge clk) begin
		if (!rst && ready) begin
			if (expect_q.size() == 0) begin
				fail_run("ready pulsed with no fetch outstanding");
			end else begin
				expected_addr = expect_q.pop_front();
				check_value("inst", expected_inst(expected_addr), inst);
			end
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			fail_run("timeout, cache stopped answering fetches");
		end
	end

	initial begin
		rst          = 1'b1;
		addr.raw     = '0;
		valid        = 1'b0;
		flush        = 1'b0;
		inv_valid    = 1'b0;
		inv_addr.raw = '0;
		repeat (8) @(negedge clk);
		rst = 1'b0;

		test_name = "cold_miss";
		fetch_word(64'h100, 1'b1);
		for (int w = 1; w < 4; w++) begin
			fetch_word(64'h100 + 64'(w * 4), 1'b0);
		end

		test_name = "back_to_back";
		fetch_word(64'h040, 1'b1);
		fetch_word(64'h080, 1'b1);
		stream_hits(64'h040, 64'h080);

		// index 5 in every tag; only the latest refill of a set is a sure hit
		test_name = "set_conflict";
		for (int t = 0; t < 4; t++) begin
			fetch_word(64'h050 + 64'(t * 'h400), 1'b1);
		end
		for (int t = 0; t < 4; t++) begin
			fetch_word(64'h054 + 64'(t * 'h400), 1'b0);
		end
		fetch_word(64'h1050, 1'b1);
		fetch_word(64'h1058, 1'b0);

		test_name = "invalidate";
		fetch_word(64'h108, 1'b0);
		invalidate(64'h104);
		fetch_word(64'h10C, 1'b1);
		fetch_word(64'h100, 1'b0);

		test_name = "flush";
		flushed_fetch(64'h1050);
		fetch_word(64'h1054, 1'b0);

		test_name = "random";
		for (int n = 0; n < 200; n++) begin
			draw_bits(10, rand_bits);
			fetch_word({52'b0, rand_bits[9:0], 2'b00}, 1'b0);
		end

		// a stray response in these cycles still reaches the checker
		repeat (2) @(negedge clk);
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

/* tests/icache_properties.sv */
`timescale 1ns/1ps

module icache_properties (
	input logic                                  clk,
	input logic                                  rst,
	input logic                                  valid,
	input logic                                  ready,
	input logic                                  arvalid,
	input logic                                  arready,
	input logic                                  idle,
	input logic [icache_pkg::NUM_WAYS-1:0]       refill_way,
	input logic [icache_pkg::WORDS_PER_LINE-1:0] word_en,
	input logic                                  rvalid
);

	// a response needs a request sampled at the edge before it
	ready_needs_request: assert property (
		@(posedge clk) disable iff (rst) ready && !valid |=> !ready
	) else $error("ready repeated without a new request");

	// read address held until the memory takes it
	arvalid_held: assert property (
		@(posedge clk) disable iff (rst) arvalid && !arready |=> arvalid
	) else $error("arvalid dropped before arready");

	// exactly one victim way while refilling
	victim_onehot: assert property (
		@(posedge clk) disable iff (rst) !idle |-> $onehot(refill_way)
	) else $error("refill_way not one-hot during refill");

	// one word written per beat
	word_en_onehot: assert property (
		@(posedge clk) disable iff (rst) !idle && rvalid |-> $onehot(word_en)
	) else $error("word_en not one-hot on a refill beat");

	// memory only streams for an accepted request
	no_beat_in_idle: assert property (
		@(posedge clk) disable iff (rst) idle |-> !rvalid
	) else $error("refill beat while controller idle");

endmodule

bind icache_top icache_properties u_props (
	.clk        (clk),
	.rst        (rst),
	.valid      (valid),
	.ready      (ready),
	.arvalid    (req.arvalid),
	.arready    (arready),
	.idle       (idle),
	.refill_way (refill_way),
	.word_en    (word_en),
	.rvalid     (beat.rvalid)
);

/* source/icache_top.sv */
`timescale 1ns/1ps

module icache_top #(
	parameter int MEM_LATENCY = 3
) (
	input  logic                     clk,
	input  logic                     rst,
	input  icache_pkg::fetch_addr_u  addr,
	input  logic                     valid,
	input  logic                     flush,
	input  logic                     inv_valid,
	input  icache_pkg::fetch_addr_u  inv_addr,
	output logic [31:0]              inst,
	output logic                     ready,
	output logic                     hit
);

	icache_pkg::refill_req_t                                 req;
	icache_pkg::refill_beat_t                                beat;
	logic                                                    arready;
	logic                                                    idle;
	logic [icache_pkg::NUM_WAYS-1:0]                         refill_way;
	logic [icache_pkg::WORDS_PER_LINE-1:0]                   word_en;
	logic [icache_pkg::NUM_WAYS-1:0]                         way_hit;
	logic [icache_pkg::NUM_WAYS-1:0][icache_pkg::LINE_W-1:0] lines;

	icache_ctrl u_ctrl (
		.clk        (clk),
		.rst        (rst),
		.addr       (addr),
		.valid      (valid),
		.any_hit    (hit),
		.arready    (arready),
		.beat       (beat),
		.req        (req),
		.refill_way (refill_way),
		.word_en    (word_en),
		.idle       (idle)
	);

	icache_tag_array u_tags (
		.clk        (clk),
		.rst        (rst),
		.addr       (addr),
		.idle       (idle),
		.refill_way (refill_way),
		.beat       (beat),
		.inv_valid  (inv_valid),
		.inv_addr   (inv_addr),
		.way_hit    (way_hit),
		.hit        (hit)
	);

	// line address carries the fetch index in idle and the refill index after
	for (genvar w = 0; w < icache_pkg::NUM_WAYS; w++) begin : g_way
		icache_data_way u_way (
			.clk     (clk),
			.rd_en   (way_hit[w]),
			.wr_en   (refill_way[w]),
			.word_en (word_en),
			.index   (req.line_addr[icache_pkg::INDEX_W-1:0]),
			.wdata   (beat.rdata),
			.line    (lines[w])
		);
	end

	icache_resp u_resp (
		.clk     (clk),
		.rst     (rst),
		.flush   (flush),
		.valid   (valid),
		.hit     (hit),
		.way_hit (way_hit),
		.addr    (addr),
		.lines   (lines),
		.ready   (ready),
		.inst    (inst)
	);

	refill_memory #(
		.MEM_LATENCY (MEM_LATENCY)
	) u_mem (
		.clk     (clk),
		.rst     (rst),
		.req     (req),
		.arready (arready),
		.beat    (beat)
	);

endmodule

/* source/refill_memory.sv */
`timescale 1ns/1ps

module refill_memory #(
	parameter int MEM_LATENCY = 3
) (
	input  logic                      clk,
	input  logic                      rst,
	input  icache_pkg::refill_req_t   req,
	output logic                      arready,
	output icache_pkg::refill_beat_t  beat
);

	// 4 KiB of 32-bit words, addresses wrap
	localparam int MEM_WORDS = 1024;
	localparam int MEM_AW    = $clog2(MEM_WORDS);
	localparam int CNT_W     = $clog2(MEM_LATENCY + 2);

	logic [31:0] mem [MEM_WORDS];

	logic              busy_q;
	logic [CNT_W-1:0]  wait_q;
	logic [1:0]        beat_idx_q;
	logic [MEM_AW-3:0] base_q;
	logic              rvalid_q;
	logic              rlast_q;
	logic [31:0]       rdata_q;

	// backing store holds the same pattern the package describes
	initial begin
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = icache_pkg::mem_word(32'(i));
		end
	end

	// one outstanding burst at a time
	assign arready = !busy_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy_q     <= 1'b0;
			wait_q     <= '0;
			beat_idx_q <= '0;
			rvalid_q   <= 1'b0;
			rlast_q    <= 1'b0;
		end else begin
			rvalid_q <= 1'b0;
			rlast_q  <= 1'b0;
			if (!busy_q) begin
				if (req.arvalid) begin
					busy_q     <= 1'b1;
					wait_q     <= CNT_W'(MEM_LATENCY);
					beat_idx_q <= '0;
				end
			end else if (wait_q != '0) begin
				// access latency
				wait_q <= wait_q - 1'b1;
			end else begin
				// stream words 0..3 on consecutive cycles
				rvalid_q   <= 1'b1;
				rlast_q    <= beat_idx_q == 2'd3;
				beat_idx_q <= beat_idx_q + 2'd1;
				if (beat_idx_q == 2'd3) begin
					busy_q <= 1'b0;
				end
			end
		end
	end

	// line base and beat data
	always_ff @(posedge clk) begin
		if (!busy_q && req.arvalid) begin
			base_q <= req.line_addr[MEM_AW-3:0];
		end
		rdata_q <= mem[{base_q, beat_idx_q}];
	end

	assign beat.rdata  = rdata_q;
	assign beat.rvalid = rvalid_q;
	assign beat.rlast  = rlast_q;

endmodule

/* source/icache_resp.sv */
`timescale 1ns/1ps

module icache_resp (
	input  logic                                                 clk,
	input  logic                                                 rst,
	input  logic                                                 flush,
	input  logic                                                 valid,
	input  logic                                                 hit,
	input  logic [icache_pkg::NUM_WAYS-1:0]                      way_hit,
	input  icache_pkg::fetch_addr_u                              addr,
	input  logic [icache_pkg::NUM_WAYS-1:0][icache_pkg::LINE_W-1:0] lines,
	output logic                                                 ready,
	output logic [31:0]                                          inst
);

	logic                            ready_q;
	logic [icache_pkg::NUM_WAYS-1:0] mask_q;
	logic [1:0]                      word_q;
	logic [icache_pkg::LINE_W-1:0]   sel_line;

	// second stage of a hit, flush kills the response due next cycle
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			ready_q <= 1'b0;
			mask_q  <= '0;
		end else if (valid && hit) begin
			ready_q <= 1'b1;
			mask_q  <= way_hit;
		end else begin
			ready_q <= 1'b0;
			mask_q  <= '0;
		end
	end

	// word offset of the request, only looked at while ready is high
	always_ff @(posedge clk) begin
		word_q <= addr.fields.word;
	end

	// mask is one-hot on a hit, so an or of the ways selects it
	always_comb begin
		sel_line = '0;
		for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
			if (mask_q[w]) begin
				sel_line = sel_line | lines[w];
			end
		end
	end

	assign inst  = sel_line[word_q*32 +: 32];
	assign ready = ready_q;

endmodule

/* source/icache_ctrl.sv */
`timescale 1ns/1ps

module icache_ctrl (
	input  logic                                   clk,
	input  logic                                   rst,
	input  icache_pkg::fetch_addr_u                addr,
	input  logic                                   valid,
	input  logic                                   any_hit,
	input  logic                                   arready,
	input  icache_pkg::refill_beat_t               beat,
	output icache_pkg::refill_req_t                req,
	output logic [icache_pkg::NUM_WAYS-1:0]        refill_way,
	output logic [icache_pkg::WORDS_PER_LINE-1:0]  word_en,
	output logic                                   idle
);

	localparam int WAYS  = icache_pkg::NUM_WAYS;
	localparam int WORDS = icache_pkg::WORDS_PER_LINE;

	// two states, idle and refill
	localparam logic S_IDLE   = 1'b0;
	localparam logic S_REFILL = 1'b1;

	logic                               state_q;
	// victim candidate, rotates through the ways while idle
	logic [WAYS-1:0]                    victim_q;
	// way picked at acceptance, written by the whole burst
	logic [WAYS-1:0]                    way_q;
	// word slot of the next beat
	logic [WORDS-1:0]                   beat_q;
	// line of the refill in flight
	logic [icache_pkg::LINE_ADDR_W-1:0] line_q;
	logic                               accept;

	assign idle = state_q == S_IDLE;

	// miss request, held while the memory is busy
	assign req.arvalid   = idle && valid && !any_hit;
	// data ways index with the low bits, so idle shows the fetch line
	assign req.line_addr = idle ? addr.raw[31:4] : line_q;

	assign accept = req.arvalid && arready;

	// way and word enables only exist during a refill
	assign refill_way = idle ? '0 : way_q;
	assign word_en    = (!idle && beat.rvalid) ? beat_q : '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q  <= S_IDLE;
			victim_q <= WAYS'(1);
			way_q    <= '0;
			beat_q   <= WORDS'(1);
			line_q   <= '0;
		end else if (idle) begin
			// rotator advances every idle cycle
			victim_q <= {victim_q[WAYS-2:0], victim_q[WAYS-1]};
			if (accept) begin
				state_q <= S_REFILL;
				way_q   <= victim_q;
				line_q  <= addr.raw[31:4];
				// burst starts at word 0
				beat_q  <= WORDS'(1);
			end
		end else begin
			// victim frozen, beat slot moves on each data beat
			if (beat.rvalid) begin
				beat_q <= {beat_q[WORDS-2:0], beat_q[WORDS-1]};
				if (beat.rlast) begin
					state_q <= S_IDLE;
				end
			end
		end
	end

endmodule

/* source/icache_tag_array.sv */
`timescale 1ns/1ps

module icache_tag_array (
	input  logic                             clk,
	input  logic                             rst,
	input  icache_pkg::fetch_addr_u          addr,
	input  logic                             idle,
	input  logic [icache_pkg::NUM_WAYS-1:0]  refill_way,
	input  icache_pkg::refill_beat_t         beat,
	input  logic                             inv_valid,
	input  icache_pkg::fetch_addr_u          inv_addr,
	output logic [icache_pkg::NUM_WAYS-1:0]  way_hit,
	output logic                             hit
);

	// tag storage per way and set
	logic [icache_pkg::TAG_W-1:0] tags [icache_pkg::NUM_WAYS][icache_pkg::NUM_SETS];
	// valid bits, one vector of sets per way
	logic [icache_pkg::NUM_WAYS-1:0][icache_pkg::NUM_SETS-1:0] valid_q;

	// line being refilled, captured while the controller is idle
	logic [icache_pkg::TAG_W-1:0]   fill_tag_q;
	logic [icache_pkg::INDEX_W-1:0] fill_index_q;

	logic                            install;
	logic [icache_pkg::NUM_WAYS-1:0] inv_match;

	// lookup of all four ways at the fetch index
	always_comb begin
		for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
			way_hit[w] = valid_q[w][addr.fields.index] &&
				(tags[w][addr.fields.index] == addr.fields.tag);
		end
	end

	// no hits reported while a refill is in progress
	assign hit = idle && (way_hit != '0);

	// invalidate compares tags only, valid state does not matter
	always_comb begin
		for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
			inv_match[w] = tags[w][inv_addr.fields.index] == inv_addr.fields.tag;
		end
	end

	// last beat of the burst closes the refill
	assign install = (refill_way != '0) && beat.rvalid && beat.rlast;

	// the accepting edge is the last idle edge, so this holds the refill line
	always_ff @(posedge clk) begin
		if (idle) begin
			fill_tag_q   <= addr.fields.tag;
			fill_index_q <= addr.fields.index;
		end
	end

	always_ff @(posedge clk) begin
		for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
			if (install && refill_way[w]) begin
				tags[w][fill_index_q] <= fill_tag_q;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
		end else begin
			// store-to-code path, drop every way holding the line
			if (inv_valid) begin
				for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
					if (inv_match[w]) begin
						valid_q[w][inv_addr.fields.index] <= 1'b0;
					end
				end
			end
			// later assignment, so an install of the same line wins
			if (install) begin
				for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
					if (refill_way[w]) begin
						valid_q[w][fill_index_q] <= 1'b1;
					end
				end
			end
		end
	end

endmodule

/* source/icache_data_way.sv */
`timescale 1ns/1ps

module icache_data_way (
	input  logic                                   clk,
	input  logic                                   rd_en,
	input  logic                                   wr_en,
	input  logic [icache_pkg::WORDS_PER_LINE-1:0]  word_en,
	input  logic [icache_pkg::INDEX_W-1:0]         index,
	input  logic [31:0]                            wdata,
	output logic [icache_pkg::LINE_W-1:0]          line
);

	localparam int WORD_W = icache_pkg::LINE_W / icache_pkg::WORDS_PER_LINE;

	// one line per set
	logic [icache_pkg::LINE_W-1:0] ram [icache_pkg::NUM_SETS];

	// per-word write, one beat of the burst at a time
	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int k = 0; k < icache_pkg::WORDS_PER_LINE; k++) begin
				if (word_en[k]) begin
					ram[index][k*WORD_W +: WORD_W] <= wdata;
				end
			end
		end
	end

	// registered read, data valid the cycle after rd_en
	// output holds its value until the next read
	always_ff @(posedge clk) begin
		if (rd_en) begin
			line <= ram[index];
		end
	end

endmodule

/* source/icache_pkg.sv */
package icache_pkg;

	// cache geometry
	localparam int NUM_WAYS       = 4;
	localparam int NUM_SETS       = 64;
	localparam int WORDS_PER_LINE = 4;
	localparam int ADDR_W         = 64;
	localparam int TAG_W          = 54;
	localparam int INDEX_W        = 6;
	localparam int LINE_W         = 128;

	// line address sent to the refill memory, fetch address bits 31..4
	localparam int LINE_ADDR_W = 28;

	// fields of a fetch address, msb first
	typedef struct packed {
		logic [TAG_W-1:0]   tag;
		logic [INDEX_W-1:0] index;
		logic [1:0]         word;
		logic [1:0]         byte_off;
	} fetch_fields_t;

	// one fetch address, seen as a byte address or as cache fields
	typedef union packed {
		logic [ADDR_W-1:0] raw;
		fetch_fields_t     fields;
	} fetch_addr_u;

	// read address channel toward the refill memory
	typedef struct packed {
		logic [LINE_ADDR_W-1:0] line_addr;
		logic                   arvalid;
	} refill_req_t;

	// one data beat of a line burst
	typedef struct packed {
		logic [31:0] rdata;
		logic        rvalid;
		logic        rlast;
	} refill_beat_t;

	// contents of the backing store at a given word address
	function automatic logic [31:0] mem_word(input logic [31:0] word_addr);
		logic [31:0] scrambled;
		scrambled = word_addr ^ 32'h5A5A_0000;
		return scrambled + (word_addr * 32'd3);
	endfunction

endpackage
